/* hdl/xu_cfg.svh */
// Configuration macros for the fixed-point execute slice: operand width and opcodes
`ifndef XU_CFG_SVH
`define XU_CFG_SVH

// Operand width and number of byte lanes
`define GPR_WIDTH 64
`define GPR_BYTES (`GPR_WIDTH/8)

// Arithmetic opcodes
`define OP_ADD    4'h0
`define OP_SUBF   4'h1
`define OP_NEG    4'h2

// Logical opcodes, 4'h3 to 4'h7 are unused and decode as add
`define OP_AND    4'h8
`define OP_OR     4'h9
`define OP_XOR    4'hA
`define OP_NAND   4'hB
`define OP_NOR    4'hC
`define OP_ANDC   4'hD
`define OP_ORC    4'hE
`define OP_EQV    4'hF

`endif

/* hdl/xu_alu_pkg.sv */
// Operand, opcode and control types shared by the fixed-point execute slice
`include "xu_cfg.svh"

package xu_alu_pkg;

   // Operand or result, bit 0 is the most significant bit
   typedef logic [0:`GPR_WIDTH-1] gpr_t;

   // One bit per byte lane, lane 0 holds the most significant byte
   typedef logic [0:`GPR_BYTES-1] byte_msk_t;

   typedef logic [3:0] alu_op_t;

   // Truth table of a two-input function, indexed by {rs1 bit, rs2 bit}
   typedef logic [3:0] log_tt_t;

   // Per-op controls carried from ex1 into ex2
   typedef struct packed {
      // Carry into the least significant bit of the adder
      logic    add_ci;
      // High means carry and overflow come from bit 0
      logic    msb_64b_sel;
      // Negate adds the inverted rs1 to zero
      logic    rs2_zero;
      // Take the logical result instead of the sum
      logic    sel_log;
      log_tt_t log_tt;
   } alu_ctl_t;

   // Truth tables of the eight logical functions
   localparam log_tt_t TT_AND  = 4'b1000;
   localparam log_tt_t TT_OR   = 4'b1110;
   localparam log_tt_t TT_XOR  = 4'b0110;
   localparam log_tt_t TT_NAND = 4'b0111;
   localparam log_tt_t TT_NOR  = 4'b0001;
   localparam log_tt_t TT_ANDC = 4'b0100;
   localparam log_tt_t TT_ORC  = 4'b1101;
   localparam log_tt_t TT_EQV  = 4'b1001;

endpackage

/* hdl/xu_alu_dec.sv */
// Execute slice ex1 decoder: opcode to adder invert, carry in and logic controls
`timescale 1ns/10ps
`include "xu_cfg.svh"

module xu_alu_dec
   import xu_alu_pkg::*;
(
   input  alu_op_t   ex1_op,
   input  logic      ex1_is_32b,
   output byte_msk_t add_rs1_inv,
   output alu_ctl_t  ex1_ctl
);

   logic    rs1_inv_all;
   logic    log_op;
   log_tt_t log_tt;

   always_comb begin
      rs1_inv_all = 1'b0;
      log_op      = 1'b0;
      log_tt      = '0;
      case (ex1_op)
         `OP_SUBF: begin
            rs1_inv_all = 1'b1;
         end
         `OP_NEG: begin
            rs1_inv_all = 1'b1;
         end
         `OP_AND: begin
            log_op = 1'b1;
            log_tt = TT_AND;
         end
         `OP_OR: begin
            log_op = 1'b1;
            log_tt = TT_OR;
         end
         `OP_XOR: begin
            log_op = 1'b1;
            log_tt = TT_XOR;
         end
         `OP_NAND: begin
            log_op = 1'b1;
            log_tt = TT_NAND;
         end
         `OP_NOR: begin
            log_op = 1'b1;
            log_tt = TT_NOR;
         end
         `OP_ANDC: begin
            log_op = 1'b1;
            log_tt = TT_ANDC;
         end
         `OP_ORC: begin
            log_op = 1'b1;
            log_tt = TT_ORC;
         end
         `OP_EQV: begin
            log_op = 1'b1;
            log_tt = TT_EQV;
         end
         // Add and the unused codes need no inversion and no carry in
         default: begin
            rs1_inv_all = 1'b0;
         end
      endcase
   end

   // Subtract-from is ~rs1 + rs2 + 1, negate is ~rs1 + 0 + 1
   assign add_rs1_inv         = {`GPR_BYTES{rs1_inv_all}};
   assign ex1_ctl.add_ci      = rs1_inv_all;
   assign ex1_ctl.msb_64b_sel = ~ex1_is_32b;
   assign ex1_ctl.rs2_zero    = (ex1_op == `OP_NEG);
   assign ex1_ctl.sel_log     = log_op;
   assign ex1_ctl.log_tt      = log_tt;

endmodule

/* hdl/xu_alu_add.sv */
// Execute slice ex2 adder with latched rs1 inversion, carry out and signed overflow
`timescale 1ns/10ps
`include "xu_cfg.svh"

module xu_alu_add
   import xu_alu_pkg::*;
(
   input  logic      nclk,
   input  logic      rst_n,
   input  logic      ex1_act,
   input  byte_msk_t dec_alu_ex1_add_rs1_inv,
   input  logic      dec_alu_ex2_add_ci,
   input  logic      ex2_msb_64b_sel,
   input  gpr_t      ex2_rs1,
   input  gpr_t      ex2_rs2,
   output gpr_t      ex2_add_rt,
   output logic      ex2_add_ovf,
   output logic      ex2_add_ca
);

   localparam int HALF = `GPR_WIDTH/2;

   gpr_t          ex1_rs1_inv;
   gpr_t          ex2_rs1_inv_q;
   gpr_t          ex2_x;
   logic [0:HALF] lo_sum;
   logic [0:HALF] hi_sum;
   logic          ex2_cout_32;
   logic          ex2_cout_00;
   logic          sgn00_32;
   logic          sgn11_32;
   logic          sgn00_64;
   logic          sgn11_64;

   // Each byte lane bit covers the eight bits of its lane
   for (genvar i = 0; i < `GPR_WIDTH; i++) begin : g_rs1_inv
      assign ex1_rs1_inv[i] = dec_alu_ex1_add_rs1_inv[i/8];
   end

   always_ff @(posedge nclk) begin
      if (!rst_n) begin
         ex2_rs1_inv_q <= '0;
      end else if (ex1_act) begin
         ex2_rs1_inv_q <= ex1_rs1_inv;
      end
   end

   assign ex2_x = ex2_rs1 ^ ex2_rs1_inv_q;

   // The low word is added first so its carry out is visible at bit 32
   assign lo_sum = {1'b0, ex2_x[HALF:`GPR_WIDTH-1]}
                 + {1'b0, ex2_rs2[HALF:`GPR_WIDTH-1]}
                 + {{HALF{1'b0}}, dec_alu_ex2_add_ci};
   assign ex2_cout_32 = lo_sum[0];

   assign hi_sum = {1'b0, ex2_x[0:HALF-1]}
                 + {1'b0, ex2_rs2[0:HALF-1]}
                 + {{HALF{1'b0}}, ex2_cout_32};
   assign ex2_cout_00 = hi_sum[0];

   assign ex2_add_rt = {hi_sum[1:HALF], lo_sum[1:HALF]};

   // Both operand signs equal at the selected position, per mode
   assign sgn00_32 = ~ex2_msb_64b_sel & ~ex2_x[HALF] & ~ex2_rs2[HALF];
   assign sgn11_32 = ~ex2_msb_64b_sel &  ex2_x[HALF] &  ex2_rs2[HALF];
   assign sgn00_64 =  ex2_msb_64b_sel & ~ex2_x[0]    & ~ex2_rs2[0];
   assign sgn11_64 =  ex2_msb_64b_sel &  ex2_x[0]    &  ex2_rs2[0];

   // Overflow when the result sign differs from the shared operand sign
   assign ex2_add_ovf = (sgn00_32 &  ex2_add_rt[HALF])
                      | (sgn11_32 & ~ex2_add_rt[HALF])
                      | (sgn00_64 &  ex2_add_rt[0])
                      | (sgn11_64 & ~ex2_add_rt[0]);

   assign ex2_add_ca = ex2_msb_64b_sel ? ex2_cout_00 : ex2_cout_32;

endmodule

/* hdl/xu_alu_rslt.sv */
// Execute slice ex2 logic unit and result select, registered into ex3
`timescale 1ns/10ps
`include "xu_cfg.svh"

module xu_alu_rslt
   import xu_alu_pkg::*;
(
   input  logic     nclk,
   input  logic     rst_n,
   input  logic     ex2_val,
   input  alu_ctl_t ex2_ctl,
   input  gpr_t     ex2_rs1,
   input  gpr_t     ex2_rs2,
   input  gpr_t     ex2_add_rt,
   input  logic     ex2_add_ca,
   input  logic     ex2_add_ovf,
   output logic     ex3_val,
   output gpr_t     ex3_rt,
   output logic     ex3_ca,
   output logic     ex3_ov
);

   gpr_t ex2_log_rt;
   gpr_t ex2_rt;
   logic ex2_ca;
   logic ex2_ov;

   // Each result bit looks up the truth table with its rs1 and rs2 bits
   for (genvar i = 0; i < `GPR_WIDTH; i++) begin : g_log
      assign ex2_log_rt[i] = ex2_ctl.log_tt[{ex2_rs1[i], ex2_rs2[i]}];
   end

   always_comb begin
      if (ex2_ctl.sel_log) begin
         ex2_rt = ex2_log_rt;
         ex2_ca = 1'b0;
         ex2_ov = 1'b0;
      end else begin
         ex2_rt = ex2_add_rt;
         ex2_ca = ex2_add_ca;
         ex2_ov = ex2_add_ovf;
      end
   end

   // Valid advances every cycle so bubbles come out as zero valid
   always_ff @(posedge nclk) begin
      if (!rst_n) begin
         ex3_val <= 1'b0;
      end else begin
         ex3_val <= ex2_val;
      end
   end

   // Result only loads for a valid op and otherwise holds the last one
   always_ff @(posedge nclk) begin
      if (!rst_n) begin
         ex3_rt <= '0;
         ex3_ca <= 1'b0;
         ex3_ov <= 1'b0;
      end else if (ex2_val) begin
         ex3_rt <= ex2_rt;
         ex3_ca <= ex2_ca;
         ex3_ov <= ex2_ov;
      end
   end

endmodule

/* hdl/xu_alu.sv */
// Fixed-point execute slice top: ex1 decode, ex2 add and logic, ex3 result
`timescale 1ns/10ps

module xu_alu
   import xu_alu_pkg::*;
(
   input  logic    nclk,
   input  logic    rst_n,

   // Issue in ex1
   input  logic    ex1_val,
   input  alu_op_t ex1_op,
   input  logic    ex1_is_32b,
   input  gpr_t    ex1_rs1,
   input  gpr_t    ex1_rs2,

   // Result in ex3
   output logic    ex3_val,
   output gpr_t    ex3_rt,
   output logic    ex3_ca,
   output logic    ex3_ov
);

   byte_msk_t add_rs1_inv;
   alu_ctl_t  ex1_ctl;

   logic      ex2_val;
   alu_ctl_t  ex2_ctl;
   gpr_t      ex2_rs1;
   gpr_t      ex2_rs2;

   gpr_t      ex2_add_rt;
   logic      ex2_add_ca;
   logic      ex2_add_ovf;

   xu_alu_dec i_dec (
      .ex1_op      (ex1_op),
      .ex1_is_32b  (ex1_is_32b),
      .add_rs1_inv (add_rs1_inv),
      .ex1_ctl     (ex1_ctl)
   );

   always_ff @(posedge nclk) begin
      if (!rst_n) begin
         ex2_val <= 1'b0;
         ex2_ctl <= '0;
      end else begin
         ex2_val <= ex1_val;
         if (ex1_val) begin
            ex2_ctl <= ex1_ctl;
         end
      end
   end

   // Operands hold while no op is issued
   always_ff @(posedge nclk) begin
      if (ex1_val) begin
         ex2_rs1 <= ex1_rs1;
         // Negate adds against zero
         ex2_rs2 <= ex1_ctl.rs2_zero ? '0 : ex1_rs2;
      end
   end

   xu_alu_add i_add (
      .nclk                    (nclk),
      .rst_n                   (rst_n),
      .ex1_act                 (ex1_val),
      .dec_alu_ex1_add_rs1_inv (add_rs1_inv),
      .dec_alu_ex2_add_ci      (ex2_ctl.add_ci),
      .ex2_msb_64b_sel         (ex2_ctl.msb_64b_sel),
      .ex2_rs1                 (ex2_rs1),
      .ex2_rs2                 (ex2_rs2),
      .ex2_add_rt              (ex2_add_rt),
      .ex2_add_ovf             (ex2_add_ovf),
      .ex2_add_ca              (ex2_add_ca)
   );

   xu_alu_rslt i_rslt (
      .nclk        (nclk),
      .rst_n       (rst_n),
      .ex2_val     (ex2_val),
      .ex2_ctl     (ex2_ctl),
      .ex2_rs1     (ex2_rs1),
      .ex2_rs2     (ex2_rs2),
      .ex2_add_rt  (ex2_add_rt),
      .ex2_add_ca  (ex2_add_ca),
      .ex2_add_ovf (ex2_add_ovf),
      .ex3_val     (ex3_val),
      .ex3_rt      (ex3_rt),
      .ex3_ca      (ex3_ca),
      .ex3_ov      (ex3_ov)
   );

endmodule

/* verif/xu_alu_tb.sv */
// Testbench for the fixed-point execute slice with LFSR stimulus, reference model and checks
`timescale 1ns/10ps
`include "xu_cfg.svh"

module xu_alu_tb
   import xu_alu_pkg::*;
();

   localparam int CLK_PERIOD  = 100;
   localparam int RST_CYCLES  = 10;
   localparam int N_RANDOM    = 400;
   localparam int N_OPS       = N_RANDOM + 64;
   // An op takes at most four slots counting its gap
   localparam int WATCHDOG_NS = (RST_CYCLES + 4 * N_OPS + 20) * CLK_PERIOD;

   typedef struct packed {
      logic [63:0] rt;
      logic        ca;
      logic        ov;
   } exp_t;

   logic    nclk;
   logic    rst_n;
   logic    ex1_val;
   alu_op_t ex1_op;
   logic    ex1_is_32b;
   gpr_t    ex1_rs1;
   gpr_t    ex1_rs2;
   logic    ex3_val;
   gpr_t    ex3_rt;
   logic    ex3_ca;
   logic    ex3_ov;

   logic [31:0] lfsr_state = 32'hd452_3e1e;
   logic        seen_out   = 1'b0;

   // Entry 1 of the model pipe lines up with the DUT ex3 register
   logic m_val [0:1];
   exp_t m_exp [0:1];

   xu_alu i_dut (
      .nclk       (nclk),
      .rst_n      (rst_n),
      .ex1_val    (ex1_val),
      .ex1_op     (ex1_op),
      .ex1_is_32b (ex1_is_32b),
      .ex1_rs1    (ex1_rs1),
      .ex1_rs2    (ex1_rs2),
      .ex3_val    (ex3_val),
      .ex3_rt     (ex3_rt),
      .ex3_ca     (ex3_ca),
      .ex3_ov     (ex3_ov)
   );

   initial begin
      nclk = 1'b0;
      forever #(CLK_PERIOD / 2) nclk = ~nclk;
   end

   // Taps 32, 22, 2 and 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic draw(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[62:0], lfsr_state[0]};
      end
   endtask

   // Expected result from the instruction definitions with bit 63 as the MSB
   function automatic exp_t model_op(input logic [3:0] op, input logic is_32b,
                                     input logic [63:0] rs1, input logic [63:0] rs2);
      exp_t        e;
      logic [63:0] a;
      logic [63:0] b;
      logic        ci;
      logic [64:0] sum;
      logic [32:0] lo;
      logic        logical;
      a       = rs1;
      b       = rs2;
      ci      = 1'b0;
      logical = 1'b1;
      e       = '0;
      case (op)
         `OP_AND:  e.rt = rs1 & rs2;
         `OP_OR:   e.rt = rs1 | rs2;
         `OP_XOR:  e.rt = rs1 ^ rs2;
         `OP_NAND: e.rt = ~(rs1 & rs2);
         `OP_NOR:  e.rt = ~(rs1 | rs2);
         `OP_ANDC: e.rt = rs1 & ~rs2;
         `OP_ORC:  e.rt = rs1 | ~rs2;
         `OP_EQV:  e.rt = ~(rs1 ^ rs2);
         default: begin
            logical = 1'b0;
            if (op == `OP_SUBF || op == `OP_NEG) begin
               a  = ~rs1;
               ci = 1'b1;
            end
            if (op == `OP_NEG) begin
               b = '0;
            end
         end
      endcase
      if (!logical) begin
         sum  = {1'b0, a} + {1'b0, b} + {64'd0, ci};
         lo   = {1'b0, a[31:0]} + {1'b0, b[31:0]} + {32'd0, ci};
         e.rt = sum[63:0];
         if (is_32b) begin
            e.ca = lo[32];
            e.ov = (a[31] == b[31]) && (e.rt[31] != a[31]);
         end else begin
            e.ca = sum[64];
            e.ov = (a[63] == b[63]) && (e.rt[63] != a[63]);
         end
      end
      return e;
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   always @(posedge nclk) begin
      if (!rst_n) begin
         m_val[0] <= 1'b0;
         m_val[1] <= 1'b0;
         seen_out <= 1'b0;
      end else begin
         m_val[0] <= ex1_val;
         if (ex1_val) begin
            m_exp[0] <= model_op(ex1_op, ex1_is_32b, ex1_rs1, ex1_rs2);
         end
         m_val[1] <= m_val[0];
         m_exp[1] <= m_exp[0];
         if (ex3_val) begin
            seen_out <= 1'b1;
         end
      end
   end

   // The ex3 outputs are stable at the falling edge
   a_val: assert property (@(negedge nclk) disable iff (!rst_n) ex3_val == m_val[1])
      else report_failure($sformatf("error: ex3_val is %h, expected %h", ex3_val, m_val[1]));
   a_rt: assert property (@(negedge nclk) disable iff (!rst_n) ex3_val |-> ex3_rt == m_exp[1].rt)
      else report_failure($sformatf("error: ex3_rt is %h, expected %h", ex3_rt, m_exp[1].rt));
   a_ca: assert property (@(negedge nclk) disable iff (!rst_n) ex3_val |-> ex3_ca == m_exp[1].ca)
      else report_failure($sformatf("error: ex3_ca is %h, expected %h", ex3_ca, m_exp[1].ca));
   a_ov: assert property (@(negedge nclk) disable iff (!rst_n) ex3_val |-> ex3_ov == m_exp[1].ov)
      else report_failure($sformatf("error: ex3_ov is %h, expected %h", ex3_ov, m_exp[1].ov));
   a_rst: assert property (@(negedge nclk) disable iff (!rst_n)
                           (!ex3_val && !seen_out) |-> (ex3_rt == '0 && !ex3_ca && !ex3_ov))
      else report_failure($sformatf("error: ex3_rt/ex3_ca/ex3_ov are %h/%h/%h, expected 0",
                                    ex3_rt, ex3_ca, ex3_ov));

   task automatic issue_op(input logic [3:0] op, input logic is_32b,
                           input logic [63:0] rs1, input logic [63:0] rs2);
      ex1_val    = 1'b1;
      ex1_op     = op;
      ex1_is_32b = is_32b;
      ex1_rs1    = rs1;
      ex1_rs2    = rs2;
      @(posedge nclk);
      #1;
   endtask

   // Bubbles carry random data that must never show up as valid
   task automatic idle(input int n);
      logic [63:0] r;
      for (int i = 0; i < n; i++) begin
         ex1_val = 1'b0;
         draw(4, r);
         ex1_op = r[3:0];
         draw(64, r);
         ex1_rs1 = r;
         draw(64, r);
         ex1_rs2 = r;
         @(posedge nclk);
         #1;
      end
   endtask

   initial begin
      #WATCHDOG_NS;
      report_failure("Timeout: the testbench did not finish in the expected time");
   end

   initial begin
      logic [63:0] r_op;
      logic [63:0] r_mode;
      logic [63:0] a;
      logic [63:0] b;
      logic [63:0] r_gap;
      int          gap;
      rst_n      = 1'b0;
      ex1_val    = 1'b0;
      ex1_op     = `OP_ADD;
      ex1_is_32b = 1'b0;
      ex1_rs1    = '0;
      ex1_rs2    = '0;
      repeat (RST_CYCLES) @(posedge nclk);
      #1;
      rst_n = 1'b1;
      idle(3);

      // Signed overflow at bit 0 in 64-bit mode
      issue_op(`OP_ADD, 1'b0, 64'h7FFF_FFFF_FFFF_FFFF, 64'h1);
      issue_op(`OP_ADD, 1'b0, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000);

      // Low word overflow in 32-bit mode with random upper words of opposite sign
      // A 64-bit add of these operands cannot overflow
      draw(31, a);
      draw(31, b);
      issue_op(`OP_ADD, 1'b1, {1'b0, a[30:0], 32'h7FFF_FFFF}, {1'b1, b[30:0], 32'h0000_0001});
      draw(31, a);
      draw(31, b);
      issue_op(`OP_ADD, 1'b1, {1'b1, a[30:0], 32'h7FFF_FFFF}, {1'b0, b[30:0], 32'h0000_0001});

      draw(64, b);
      issue_op(`OP_NEG, 1'b0, 64'h0, b);
      issue_op(`OP_NEG, 1'b1, 64'h0, b);
      draw(64, a);
      issue_op(`OP_NEG, 1'b0, a, b);

      for (int k = 0; k < 32; k++) begin
         draw(64, a);
         draw(64, b);
         issue_op(k[0] ? `OP_SUBF : `OP_ADD, 1'b0, a, b);
      end

      for (int j = 0; j < 16; j++) begin
         draw(64, a);
         draw(64, b);
         issue_op(`OP_AND + j[3:0], j[3], a, b);
      end

      for (int k = 0; k < N_RANDOM; k++) begin
         draw(4, r_op);
         draw(1, r_mode);
         draw(64, a);
         draw(64, b);
         issue_op(r_op[3:0], r_mode[0], a, b);
         draw(2, r_gap);
         if (r_gap[1:0] == 2'b00) begin
            draw(2, r_gap);
            gap = int'(r_gap[1:0]);
            idle(gap);
         end
      end

      idle(5);
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

/* tb.f */
+incdir+hdl
hdl/xu_alu_pkg.sv
hdl/xu_alu_dec.sv
hdl/xu_alu_add.sv
hdl/xu_alu_rslt.sv
hdl/xu_alu.sv
verif/xu_alu_tb.sv

/* run.sh */
#!/bin/sh
# Build the execute slice testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f tb.f --top-module xu_alu_tb -o xu_alu_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/xu_alu_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "Simulation finished: PASS"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
